/* logic/cal_pkg.sv */
// Shared definitions for the converter calibration block.
// Holds the register map of the bus and the widths of address decode and
// bus words. Modules refer to these by scoped name.

`default_nettype none

package cal_pkg;

  ////////////////////////////////////////
  // bus geometry
  ////////////////////////////////////////

  localparam int unsigned BUS_W = 32;  // bus address and data width
  localparam int unsigned DEC_W = 20;  // low address bits decoded, rest is window

  ////////////////////////////////////////
  // register map
  ////////////////////////////////////////

  // byte offsets inside the window, one 32-bit word per register
  typedef enum logic [DEC_W-1:0] {
    ADC_MUL0 = 'h40,  // adc ch0 gain
    ADC_SUM0 = 'h44,  // adc ch0 offset
    ADC_MUL1 = 'h48,  // adc ch1 gain
    ADC_SUM1 = 'h4C,  // adc ch1 offset
    DAC_MUL0 = 'h50,  // dac ch0 gain
    DAC_SUM0 = 'h54,  // dac ch0 offset
    DAC_MUL1 = 'h58,  // dac ch1 gain
    DAC_SUM1 = 'h5C   // dac ch1 offset
  } cal_reg_e;

endpackage : cal_pkg

`default_nettype wire

/* logic/cal_regs.sv */
// Calibration register bank on the system bus.
// Holds gain and offset for two ADC and two DAC channels. A one-cycle wen or
// ren strobe is answered by a one-cycle ack on the next clock; rdata and err
// are valid with ack. Unmapped offsets raise err, writes to them are dropped
// and reads return zero.

`timescale 1ns/1ps
`default_nettype none

module cal_regs #(
  parameter int unsigned DWM = 16,  // gain width
  parameter int unsigned DWS = 14   // offset width
) (
  input  logic                         clk,
  input  logic                         rstn,
  // system bus
  input  logic [cal_pkg::BUS_W-1:0]    sys_addr,
  input  logic [cal_pkg::BUS_W-1:0]    sys_wdata,
  input  logic                         sys_wen,
  input  logic                         sys_ren,
  output logic [cal_pkg::BUS_W-1:0]    sys_rdata,
  output logic                         sys_ack,
  output logic                         sys_err,
  // calibration values to the pipelines
  output logic signed [1:0][DWM-1:0]   adc_mul,
  output logic signed [1:0][DWS-1:0]   adc_sum,
  output logic signed [1:0][DWM-1:0]   dac_mul,
  output logic signed [1:0][DWS-1:0]   dac_sum
);

  // unity gain, binary point sits DWM-2 bits up
  localparam logic [DWM-1:0] UNITY = DWM'(1) << (DWM - 2);

  cal_pkg::cal_reg_e             reg_sel;  // decoded offset
  logic                          hit;      // offset is in the map
  logic [cal_pkg::BUS_W-1:0]     rd_val;   // sign-extended read value
  logic                          sys_en;

  assign reg_sel = cal_pkg::cal_reg_e'(sys_addr[cal_pkg::DEC_W-1:0]);
  assign sys_en  = sys_wen | sys_ren;

  ////////////////////////////////////////
  // address decode and read mux
  ////////////////////////////////////////

  // elements of a packed array come out unsigned, $signed restores the sign
  // so the assignment extends it to the bus width
  always_comb begin
    hit    = 1'b1;
    rd_val = '0;
    case (reg_sel)
      cal_pkg::ADC_MUL0: rd_val = $signed(adc_mul[0]);
      cal_pkg::ADC_SUM0: rd_val = $signed(adc_sum[0]);
      cal_pkg::ADC_MUL1: rd_val = $signed(adc_mul[1]);
      cal_pkg::ADC_SUM1: rd_val = $signed(adc_sum[1]);
      cal_pkg::DAC_MUL0: rd_val = $signed(dac_mul[0]);
      cal_pkg::DAC_SUM0: rd_val = $signed(dac_sum[0]);
      cal_pkg::DAC_MUL1: rd_val = $signed(dac_mul[1]);
      cal_pkg::DAC_SUM1: rd_val = $signed(dac_sum[1]);
      default:           hit    = 1'b0;  // hole or misaligned
    endcase
  end

  ////////////////////////////////////////
  // register writes
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      adc_mul <= {UNITY, UNITY};  // gain 1.0 on both channels
      adc_sum <= '0;
      dac_mul <= {UNITY, UNITY};
      dac_sum <= '0;
    end else if (sys_wen) begin
      case (reg_sel)
        cal_pkg::ADC_MUL0: adc_mul[0] <= sys_wdata[DWM-1:0];
        cal_pkg::ADC_SUM0: adc_sum[0] <= sys_wdata[DWS-1:0];
        cal_pkg::ADC_MUL1: adc_mul[1] <= sys_wdata[DWM-1:0];
        cal_pkg::ADC_SUM1: adc_sum[1] <= sys_wdata[DWS-1:0];
        cal_pkg::DAC_MUL0: dac_mul[0] <= sys_wdata[DWM-1:0];
        cal_pkg::DAC_SUM0: dac_sum[0] <= sys_wdata[DWS-1:0];
        cal_pkg::DAC_MUL1: dac_mul[1] <= sys_wdata[DWM-1:0];
        cal_pkg::DAC_SUM1: dac_sum[1] <= sys_wdata[DWS-1:0];
        default: ;  // unmapped, nothing changes
      endcase
    end
  end

  ////////////////////////////////////////
  // bus response
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sys_ack <= 1'b0;
      sys_err <= 1'b0;
    end else begin
      sys_ack <= sys_en;          // one cycle after the strobe
      sys_err <= sys_en & ~hit;   // rises together with ack
    end
  end

  // read data, zero on an unmapped offset
  always_ff @(posedge clk) begin
    if (sys_ren) begin
      sys_rdata <= hit ? rd_val : '0;
    end
  end

endmodule : cal_regs

`default_nettype wire

/* logic/cal_scale.sv */
// Scaling pipeline for one converter channel.
// Applies dout = clamp(((din + sum) * mul) >>> (DWM-2)) with three register
// stages: offset add, gain multiply, then rescale and saturate. One sample
// enters per clock, latency is three clocks.

`timescale 1ns/1ps
`default_nettype none

module cal_scale #(
  parameter int unsigned DWM = 16,  // gain width, unity at 1 << (DWM-2)
  parameter int unsigned DWS = 14   // sample and offset width
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic signed [DWS-1:0] din,   // raw sample
  input  logic signed [DWM-1:0] mul,   // gain
  input  logic signed [DWS-1:0] sum,   // offset
  output logic signed [DWS-1:0] dout   // calibrated sample
);

  localparam int unsigned PW = DWS + 1 + DWM;  // full product width

  // saturation limits of the output sample
  localparam logic signed [DWS-1:0] SMAX = {1'b0, {(DWS-1){1'b1}}};
  localparam logic signed [DWS-1:0] SMIN = {1'b1, {(DWS-1){1'b0}}};

  logic signed [DWS:0]    s1_sum;   // stage 1, offset applied
  logic signed [PW-1:0]   s2_prod;  // stage 2, gain applied
  logic signed [PW-1:0]   shifted;  // rescaled product
  logic signed [DWS-1:0]  sat;      // clamped result

  ////////////////////////////////////////
  // stage 1 and 2
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      s1_sum  <= '0;
      s2_prod <= '0;
    end else begin
      s1_sum  <= din + sum;      // one extra bit, cannot overflow
      s2_prod <= s1_sum * mul;   // signed, full width
    end
  end

  ////////////////////////////////////////
  // stage 3, rescale and clamp
  ////////////////////////////////////////

  // arithmetic shift rounds toward minus infinity
  assign shifted = s2_prod >>> (DWM - 2);

  always_comb begin
    if (shifted > SMAX) begin
      sat = SMAX;                  // positive full scale
    end else if (shifted < SMIN) begin
      sat = SMIN;                  // negative full scale
    end else begin
      sat = shifted[DWS-1:0];      // in range, plain truncation
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      dout <= '0;
    end else begin
      dout <= sat;
    end
  end

endmodule : cal_scale

`default_nettype wire

/* logic/cal_top.sv */
// Top level of the converter calibration block.
// The register bank on the system bus feeds gain and offset to four scaling
// pipelines, two for the ADC channels and two for the DAC channels.
// Samples flow every clock with a fixed latency of three clocks; bus
// accesses are acknowledged one clock after the strobe.

`timescale 1ns/1ps
`default_nettype none

module cal_top #(
  parameter int unsigned DWM = 16,  // gain width
  parameter int unsigned DWS = 14   // sample and offset width
) (
  input  logic                       clk,
  input  logic                       rstn,
  // system bus
  input  logic [cal_pkg::BUS_W-1:0]  sys_addr,
  input  logic [cal_pkg::BUS_W-1:0]  sys_wdata,
  input  logic                       sys_wen,
  input  logic                       sys_ren,
  output logic [cal_pkg::BUS_W-1:0]  sys_rdata,
  output logic                       sys_ack,
  output logic                       sys_err,
  // adc sample streams
  input  logic signed [DWS-1:0]      adc_in0,
  input  logic signed [DWS-1:0]      adc_in1,
  output logic signed [DWS-1:0]      adc_out0,
  output logic signed [DWS-1:0]      adc_out1,
  // dac sample streams
  input  logic signed [DWS-1:0]      dac_in0,
  input  logic signed [DWS-1:0]      dac_in1,
  output logic signed [DWS-1:0]      dac_out0,
  output logic signed [DWS-1:0]      dac_out1
);

  // calibration values, index selects the channel
  logic signed [1:0][DWM-1:0] adc_mul;
  logic signed [1:0][DWS-1:0] adc_sum;
  logic signed [1:0][DWM-1:0] dac_mul;
  logic signed [1:0][DWS-1:0] dac_sum;

  ////////////////////////////////////////
  // register bank
  ////////////////////////////////////////

  cal_regs #(.DWM(DWM), .DWS(DWS)) u_regs (
    .clk       (clk),
    .rstn      (rstn),
    .sys_addr  (sys_addr),
    .sys_wdata (sys_wdata),
    .sys_wen   (sys_wen),
    .sys_ren   (sys_ren),
    .sys_rdata (sys_rdata),
    .sys_ack   (sys_ack),
    .sys_err   (sys_err),
    .adc_mul   (adc_mul),
    .adc_sum   (adc_sum),
    .dac_mul   (dac_mul),
    .dac_sum   (dac_sum)
  );

  ////////////////////////////////////////
  // scaling pipelines
  ////////////////////////////////////////

  cal_scale #(.DWM(DWM), .DWS(DWS)) u_adc0 (
    .clk(clk), .rstn(rstn), .din(adc_in0),
    .mul(adc_mul[0]), .sum(adc_sum[0]), .dout(adc_out0)
  );

  cal_scale #(.DWM(DWM), .DWS(DWS)) u_adc1 (
    .clk(clk), .rstn(rstn), .din(adc_in1),
    .mul(adc_mul[1]), .sum(adc_sum[1]), .dout(adc_out1)
  );

  cal_scale #(.DWM(DWM), .DWS(DWS)) u_dac0 (
    .clk(clk), .rstn(rstn), .din(dac_in0),
    .mul(dac_mul[0]), .sum(dac_sum[0]), .dout(dac_out0)
  );

  cal_scale #(.DWM(DWM), .DWS(DWS)) u_dac1 (
    .clk(clk), .rstn(rstn), .din(dac_in1),
    .mul(dac_mul[1]), .sum(dac_sum[1]), .dout(dac_out1)
  );

endmodule : cal_top

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the calibration testbench with Verilator and runs it.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -Wno-fatal --top-module cal_tb -f tb.f -o cal_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/cal_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Everything OK" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi

/* tb.f */
logic/cal_pkg.sv
logic/cal_regs.sv
logic/cal_scale.sv
logic/cal_top.sv
test/cal_tb.sv

/* test/cal_tb.sv */
// Testbench for the converter calibration block.
// A table of bus writes, bus reads and sample runs is applied in order.
// Read values and error flags come from the table. Sample outputs are
// checked against a shadow copy of the registers and a scaling model.
// Random samples come from a Galois LFSR with a fixed seed.

`timescale 1ns/1ps
`default_nettype none

module cal_tb;

  localparam int DWM      = 16;
  localparam int DWS      = 14;
  localparam int NSAMP    = 64;   // samples per channel and run
  localparam int LAT      = 3;    // pipeline latency in clocks
  localparam int ACK_WAIT = 16;   // cycles before a bus access gives up
  localparam longint SMAX = 2**(DWS-1) - 1;
  localparam longint SMIN = -(2**(DWS-1));

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_RUN, OP_SAT} op_e;

  typedef struct packed {
    op_e         op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp;   // expected read value
    logic        err;   // expected error flag
  } row_t;

  logic        clk;
  logic        rstn;
  logic [31:0] sys_addr;
  logic [31:0] sys_wdata;
  logic        sys_wen;
  logic        sys_ren;
  logic [31:0] sys_rdata;
  logic        sys_ack;
  logic        sys_err;
  logic signed [DWS-1:0] adc_in0, adc_in1, dac_in0, dac_in1;
  logic signed [DWS-1:0] adc_out0, adc_out1, dac_out0, dac_out1;

  row_t                  rows[$];
  logic signed [31:0]    shadow[8];              // mul0 sum0 mul1 sum1 for adc then dac
  logic signed [DWS-1:0] exp_out[4][NSAMP];      // model output per channel
  logic [31:0]           lfsr_state = 32'ha966_f7e8;
  int                    cur_row;

  cal_top #(.DWM(DWM), .DWS(DWS)) UUT (
    .clk(clk), .rstn(rstn),
    .sys_addr(sys_addr), .sys_wdata(sys_wdata), .sys_wen(sys_wen), .sys_ren(sys_ren),
    .sys_rdata(sys_rdata), .sys_ack(sys_ack), .sys_err(sys_err),
    .adc_in0(adc_in0), .adc_in1(adc_in1), .adc_out0(adc_out0), .adc_out1(adc_out1),
    .dac_in0(dac_in0), .dac_in1(dac_in1), .dac_out0(dac_out0), .dac_out1(dac_out1)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 50 MHz
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic check(input logic signed [63:0] got, input logic signed [63:0] want,
                       input string what);
    if (got !== want) begin
      $display("mismatch at %0t ns: row %0d, %s, got %0d, expected %0d",
               $time, cur_row, what, got, want);
      $display("Something failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  // one step of a 32-bit Galois LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  function logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);  // one step per bit
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // register index of a bus offset or -1 when unmapped
  function automatic int addr_index(input logic [31:0] addr);
    logic [19:0] a;
    a = addr[19:0];
    if (a >= 20'h40 && a <= 20'h5C && a[1:0] == 2'b00) begin
      return int'((a - 20'h40) >> 2);
    end
    return -1;
  endfunction

  // stored value as read back with low bits sign-extended
  function automatic logic [31:0] reg_image(input int idx, input logic [31:0] data);
    if (idx % 2 == 0) begin
      return {{(32-DWM){data[DWM-1]}}, data[DWM-1:0]};  // gain
    end
    return {{(32-DWS){data[DWS-1]}}, data[DWS-1:0]};    // offset
  endfunction

  // offset, gain, rescale with floor, clamp
  function automatic logic signed [DWS-1:0] model(input logic signed [DWS-1:0] din,
                                                  input int c);
    longint acc;
    acc = (longint'(din) + longint'(shadow[2*c+1])) * longint'(shadow[2*c]);
    acc = acc >>> (DWM - 2);
    if (acc > SMAX) acc = SMAX;
    else if (acc < SMIN) acc = SMIN;
    return acc[DWS-1:0];
  endfunction

  task automatic drive_sample(input int c, input logic signed [DWS-1:0] x);
    case (c)
      0: adc_in0 = x;
      1: adc_in1 = x;
      2: dac_in0 = x;
      default: dac_in1 = x;
    endcase
  endtask

  function automatic logic signed [DWS-1:0] out_of(input int c);
    case (c)
      0: return adc_out0;
      1: return adc_out1;
      2: return dac_out0;
      default: return dac_out1;
    endcase
  endfunction

  ////////////////////////////////////////
  // bus access
  ////////////////////////////////////////

  task automatic bus_cycle(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                           output logic [31:0] rdata, output logic err);
    int waited;
    @(negedge clk);
    sys_addr  = addr;
    sys_wdata = data;
    sys_wen   = wr;
    sys_ren   = !wr;
    @(negedge clk);
    sys_wen = 1'b0;   // one-cycle strobe
    sys_ren = 1'b0;
    waited  = 1;
    while (!sys_ack && waited < ACK_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (!sys_ack) begin
      $display("no acknowledge came within %0d cycles at row %0d", ACK_WAIT, cur_row);
      $display("Something failed");
      $fatal(1, "bus timeout");
    end else begin
      check(waited, 1, "ack delay");
      rdata = sys_rdata;
      err   = sys_err;
      @(negedge clk);
      check(sys_ack, 0, "ack width");  // exactly one cycle
    end
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data, input logic err);
    logic [31:0] rd;
    logic        e;
    bus_cycle(1'b1, addr, data, rd, e);
    check(e, err, "write err flag");
  endtask

  task automatic read_reg(input logic [31:0] addr, input logic [31:0] want, input logic err);
    logic [31:0] rd;
    logic        e;
    bus_cycle(1'b0, addr, 32'h0, rd, e);
    check(e, err, "read err flag");
    check(rd, want, "read data");
  endtask

  ////////////////////////////////////////
  // sample runs
  ////////////////////////////////////////

  task automatic sample_run(input bit sat);
    logic [31:0]           bits;
    logic signed [DWS-1:0] x;
    int                    hi;
    int                    lo;
    hi = 0;
    lo = 0;
    for (int j = 0; j < NSAMP + LAT; j++) begin
      @(negedge clk);
      if (j >= LAT) begin
        for (int c = 0; c < 4; c++) check(out_of(c), exp_out[c][j-LAT], "sample output");
      end
      for (int c = 0; c < 4; c++) begin
        x = '0;
        if (j < NSAMP) begin
          bits = take_bits(DWS);
          x = bits[DWS-1:0];              // full scale
          exp_out[c][j] = model(x, c);
          if (exp_out[c][j] == SMAX) hi++;
          if (exp_out[c][j] == SMIN) lo++;
        end
        drive_sample(c, x);
      end
    end
    if (sat) begin
      check(hi > 0, 1, "upper clamp reached");
      check(lo > 0, 1, "lower clamp reached");
    end
  endtask

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////

  task automatic add_row(input op_e op, input logic [31:0] addr, input logic [31:0] data,
                         input logic [31:0] exp, input logic err);
    row_t r;
    r.op   = op;
    r.addr = addr;
    r.data = data;
    r.exp  = exp;
    r.err  = err;
    rows.push_back(r);
  endtask

  task automatic fill_rows();
    logic [31:0] wdat[8];
    logic [31:0] bad[3];
    // upper bits set on every word with gain 0.5 and offset 100 on adc 0
    wdat = '{32'hFFFF_2000, 32'hABCD_0064, 32'h1234_C000, 32'h5555_3F00,
             32'h8000_6000, 32'hFFFF_C0C8, 32'h0F0F_E000, 32'hFFFF_FFCE};
    bad  = '{32'h3C, 32'h60, 32'h42};
    for (int i = 0; i < 8; i++) begin
      add_row(OP_RD, 32'h40 + 4*i, 32'h0, (i % 2 == 0) ? 32'h4000 : 32'h0, 1'b0);
    end
    add_row(OP_RUN, 32'h0, 32'h0, 32'h0, 1'b0);  // unity gain so dout equals din
    for (int i = 0; i < 8; i++) begin
      add_row(OP_WR, 32'h40 + 4*i, wdat[i], 32'h0, 1'b0);
      // read all eight so a stray write shows up
      for (int k = 0; k < 8; k++) begin
        add_row(OP_RD, 32'h40 + 4*k, 32'h0,
                (k <= i) ? reg_image(k, wdat[k]) : ((k % 2 == 0) ? 32'h4000 : 32'h0),
                1'b0);
      end
    end
    for (int i = 0; i < 3; i++) begin
      add_row(OP_WR, bad[i], 32'hFFFF_FFFF, 32'h0, 1'b1);
      add_row(OP_RD, bad[i], 32'h0, 32'h0, 1'b1);
    end
    // nothing changed by later writes or by the errors
    for (int i = 0; i < 8; i++) begin
      add_row(OP_RD, 32'h40 + 4*i, 32'h0, reg_image(i, wdat[i]), 1'b0);
    end
    add_row(OP_RD, 32'h4010_0058, 32'h0, reg_image(6, wdat[6]), 1'b0);  // window ignored
    add_row(OP_RUN, 32'h0, 32'h0, 32'h0, 1'b0);
    // largest gains of both signs
    add_row(OP_WR, 32'h40, 32'h0000_7FFF, 32'h0, 1'b0);
    add_row(OP_WR, 32'h48, 32'h0000_8000, 32'h0, 1'b0);
    add_row(OP_WR, 32'h50, 32'hFFFF_7FFF, 32'h0, 1'b0);
    add_row(OP_WR, 32'h58, 32'h0000_8000, 32'h0, 1'b0);
    add_row(OP_SAT, 32'h0, 32'h0, 32'h0, 1'b0);
  endtask

  task automatic apply_row(input row_t r);
    int idx;
    idx = addr_index(r.addr);
    case (r.op)
      OP_WR: begin
        write_reg(r.addr, r.data, r.err);
        if (idx >= 0) shadow[idx] = reg_image(idx, r.data);  // keep model in step
      end
      OP_RD:   read_reg(r.addr, r.exp, r.err);
      OP_RUN:  sample_run(1'b0);
      default: sample_run(1'b1);
    endcase
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    rstn       = 1'b0;
    sys_addr   = '0;
    sys_wdata  = '0;
    sys_wen    = 1'b0;
    sys_ren    = 1'b0;
    adc_in0    = '0;
    adc_in1    = '0;
    dac_in0    = '0;
    dac_in1    = '0;
    cur_row    = 0;
    for (int i = 0; i < 8; i++) begin
      shadow[i] = (i % 2 == 0) ? 32'sd16384 : 32'sd0;  // unity gain, zero offset
    end
    fill_rows();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    for (cur_row = 0; cur_row < rows.size(); cur_row++) begin
      apply_row(rows[cur_row]);
    end
    $display("Everything OK");
    $finish;
  end

  // guard against a stuck run
  initial begin
    #200_000;
    $display("simulation did not finish within 200 us");
    $display("Something failed");
    $fatal(1, "watchdog");
  end

endmodule : cal_tb

`default_nettype wire
